/* slice_trace.txt */
# name kind op mod fmt vec a b tag exp_result exp_status
# All numeric columns in hex, flush lines carry zeros
sgnj_j_fp32        op    0 0 0 0 3f800000 c0000000 01 bf800000 00
sgnj_jn_fp32       op    0 1 0 0 bf800000 c0000000 02 3f800000 00
sgnj_jx_fp32       op    0 2 0 0 3f800000 c0400000 03 bf800000 00
sgnj_jx_neg_fp32   op    0 2 0 0 bf800000 c0400000 04 3f800000 00
sgnj_j_fp16        op    0 0 1 0 12343c00 00008000 05 ffffbc00 00
sgnj_jn_fp16       op    0 1 1 0 0000c000 00000000 a5 ffffc000 00
sgnj_vec_fp16      op    0 0 1 1 40003c00 80000000 06 c0003c00 00
sgnj_jx_vec_fp16   op    0 2 1 1 c000bc00 80003c00 07 4000bc00 00
vec_ignored_fp32   op    0 2 0 1 40490fdb 80000000 08 c0490fdb 00
min_fp32           op    1 0 0 0 3f800000 40000000 09 3f800000 00
max_fp32           op    1 1 0 0 3f800000 40000000 0a 40000000 00
min_neg_fp32       op    1 0 0 0 c0000000 bf800000 0b c0000000 00
min_zero_fp32      op    1 0 0 0 00000000 80000000 0c 80000000 00
max_zero_fp32      op    1 1 0 0 80000000 00000000 0d 00000000 00
min_qnan_fp32      op    1 0 0 0 7fc00000 3f800000 0e 3f800000 00
max_snan_fp32      op    1 1 0 0 40000000 7f800001 0f 40000000 10
min_two_nan_fp32   op    1 0 0 0 7fc00001 ff800001 10 7fc00000 10
max_two_qnan_fp32  op    1 1 0 0 7fc00000 ffc00000 11 7fc00000 00
min_fp16           op    1 0 1 0 0000c000 00003c00 12 ffffc000 00
max_neg_fp16       op    1 1 1 0 0000c000 0000bc00 13 ffffbc00 00
min_zero_fp16      op    1 0 1 0 00000000 00008000 14 ffff8000 00
max_two_nan_fp16   op    1 1 1 0 00007e00 00007c01 15 ffff7e00 10
min_qnan_fp16      op    1 0 1 0 00003c00 00007e00 16 ffff3c00 00
minmax_vec_snan_hi op    1 0 1 1 7d003c00 40004000 17 40003c00 10
minmax_vec_snan_lo op    1 0 1 1 3c007c01 40003c00 19 3c003c00 10
max_vec_fp16       op    1 1 1 1 c0003c00 bc004000 18 bc004000 00
pre_flush_a        op    1 1 0 0 3f800000 40000000 20 40000000 00
pre_flush_b        op    0 0 0 0 3f800000 80000000 21 bf800000 00
flush_drop         flush 0 0 0 0 00000000 00000000 00 00000000 00
post_flush_first   op    0 1 1 1 3c003c00 00008000 30 bc003c00 00
post_flush_min     op    1 0 0 0 bf800000 3f800000 31 bf800000 00
post_flush_scalar  op    0 2 1 0 ffffbc00 0000bc00 32 ffff3c00 00

/* flist.f */
fp_slice_pkg.sv
slice_dispatch.sv
lane_pipe.sv
result_pack.sv
fp_slice.sv
tb_clkgen.sv
tb_fp_slice.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fp_slice \
		-f flist.f -o sim_fp_slice
	@out="$$(./obj_dir/sim_fp_slice)"; echo "$$out"; \
		echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

/* tb_fp_slice.sv */
// ------------------------------------------------------------
// Trace-driven testbench for fp_slice with two pipeline stages
// Reads slice_trace.txt from the directory the run starts in
// out_ready_i back-pressure comes from a Galois LFSR
// ------------------------------------------------------------
`timescale 1ns/1ps

module tb_fp_slice;
  import fp_slice_pkg::*;

  localparam int unsigned PIPE_REGS = 2;
  localparam int unsigned TAG_W     = 8;

  logic                clk_i;
  logic                rst_i;
  logic [WORD_W-1:0]   a_i, b_i;
  logic                op_i, fmt_i, vectorial_i;
  logic [1:0]          mod_i;
  logic [TAG_W-1:0]    tag_i;
  logic                in_valid_i, flush_i;
  logic                out_ready_i = 1'b0;
  logic                in_ready_o, out_valid_o, busy_o;
  logic [WORD_W-1:0]   result_o;
  logic [STATUS_W-1:0] status_o;
  logic [TAG_W-1:0]    tag_o;

  // Trace records, one entry per line of the file
  string             tr_name[$], tr_kind[$];
  logic              tr_op[$], tr_fmt[$], tr_vec[$];
  logic [1:0]        tr_mod[$];
  logic [WORD_W-1:0] tr_a[$], tr_b[$], tr_res[$];
  logic [TAG_W-1:0]  tr_tag[$];
  logic [4:0]        tr_stat[$];

  // Items accepted by the DUT and not yet seen at the output
  string             exp_name[$];
  logic [WORD_W-1:0] exp_res[$];
  logic [4:0]        exp_stat[$];
  logic [TAG_W-1:0]  exp_tag[$];

  string             cur_name;
  logic [WORD_W-1:0] cur_res;
  logic [4:0]        cur_stat;
  logic [15:0]       lfsr = 16'd7689;
  int                fail_cnt  = 0;
  int                n_issued  = 0;
  int                n_checked = 0;
  int                n_dropped = 0;
  int                cycle_cnt = 0;
  int                cycle_limit = 0;

  tb_clkgen clkgen_i (.clk_o(clk_i));

  fp_slice #(
    .NumPipeRegs (PIPE_REGS),
    .TagWidth    (TAG_W)
  ) fp_slice_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .a_i         (a_i),
    .b_i         (b_i),
    .op_i        (op_i),
    .mod_i       (mod_i),
    .fmt_i       (fmt_i),
    .vectorial_i (vectorial_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  // Polynomial x^16 + x^14 + x^13 + x^11 + 1, shifting right
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hb400;
    end
    return state >> 1;
  endfunction

  task automatic load_trace();
    int                fd;
    int                n;
    string             line, name, kind;
    logic [31:0]       op_v, mod_v, fmt_v, vec_v, a_v, b_v, tag_v, res_v, stat_v;
    fd = $fopen("slice_trace.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open slice_trace.txt for reading");
      fail_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h", name, kind,
                  op_v, mod_v, fmt_v, vec_v, a_v, b_v, tag_v, res_v, stat_v);
      assert (n == 11) else begin
        $display("Trace line has %0d fields instead of 11: %s", n, line);
        fail_cnt++;
        continue;
      end
      tr_name.push_back(name);
      tr_kind.push_back(kind);
      tr_op.push_back(op_v[0]);
      tr_mod.push_back(mod_v[1:0]);
      tr_fmt.push_back(fmt_v[0]);
      tr_vec.push_back(vec_v[0]);
      tr_a.push_back(a_v);
      tr_b.push_back(b_v);
      tr_tag.push_back(tag_v[TAG_W-1:0]);
      tr_res.push_back(res_v);
      tr_stat.push_back(stat_v[4:0]);
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------
  // Back-pressure, ready three cycles in four on average
  // ----------------------------------------------------------
  always @(negedge clk_i) begin : drive_out_ready
    logic b0;
    logic b1;
    b0   = lfsr[0];
    lfsr = lfsr_next(lfsr);
    b1   = lfsr[0];
    lfsr = lfsr_next(lfsr);
    out_ready_i = b0 | b1;
  end

  // ----------------------------------------------------------
  // Scoreboard: record accepts, compare outputs, drop on flush
  // ----------------------------------------------------------
  always @(posedge clk_i) begin : check_outputs
    string name;
    logic  test_ok;
    if (!rst_i) begin
      if (in_valid_i && in_ready_o) begin
        exp_name.push_back(cur_name);
        exp_res.push_back(cur_res);
        exp_stat.push_back(cur_stat);
        exp_tag.push_back(tag_i);
      end
      if (out_valid_o && out_ready_i) begin
        assert (exp_name.size() != 0) else begin
          $display("Output with tag %h arrived while no item was pending", tag_o);
          fail_cnt++;
        end
        if (exp_name.size() != 0) begin
          name    = exp_name.pop_front();
          test_ok = 1'b1;
          assert (result_o == exp_res[0]) else begin
            $display("CHECK FAILED %s result expected %h actual %h",
                     name, exp_res[0], result_o);
            test_ok = 1'b0;
          end
          assert (status_o == exp_stat[0]) else begin
            $display("CHECK FAILED %s status expected %h actual %h",
                     name, exp_stat[0], status_o);
            test_ok = 1'b0;
          end
          assert (tag_o == exp_tag[0]) else begin
            $display("CHECK FAILED %s tag expected %h actual %h",
                     name, exp_tag[0], tag_o);
            test_ok = 1'b0;
          end
          void'(exp_res.pop_front());
          void'(exp_stat.pop_front());
          void'(exp_tag.pop_front());
          n_checked++;
          if (test_ok) begin
            $display("ok      %s", name);
          end else begin
            fail_cnt++;
          end
        end
      end
      // Anything still queued was in flight and is discarded
      if (flush_i) begin
        while (exp_name.size() != 0) begin
          $display("dropped %s", exp_name.pop_front());
          void'(exp_res.pop_front());
          void'(exp_stat.pop_front());
          void'(exp_tag.pop_front());
          n_dropped++;
        end
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the trace did not complete", cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin : drive_stimulus
    rst_i       = 1'b1;
    a_i         = '0;
    b_i         = '0;
    op_i        = OP_SGNJ;
    mod_i       = MOD_J;
    fmt_i       = FMT_FP32;
    vectorial_i = 1'b0;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    cur_name    = "";
    cur_res     = '0;
    cur_stat    = '0;
    load_trace();
    cycle_limit = tr_name.size() * (PIPE_REGS + 1) * 8 + 200;

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    assert (!out_valid_o && !busy_o && in_ready_o) else begin
      $display("Pipeline is not empty and ready at the end of reset");
      fail_cnt++;
    end
    rst_i = 1'b0;

    for (int idx = 0; idx < tr_name.size(); idx++) begin
      if (tr_kind[idx] == "flush") begin
        in_valid_i = 1'b0;
        flush_i    = 1'b1;
        @(posedge clk_i);
        @(negedge clk_i);
        flush_i = 1'b0;
        assert (!busy_o && !out_valid_o) else begin
          $display("Flush %s left items in the pipeline", tr_name[idx]);
          fail_cnt++;
        end
        $display("flushed %s", tr_name[idx]);
      end else begin
        a_i         = tr_a[idx];
        b_i         = tr_b[idx];
        op_i        = tr_op[idx];
        mod_i       = tr_mod[idx];
        fmt_i       = tr_fmt[idx];
        vectorial_i = tr_vec[idx];
        tag_i       = tr_tag[idx];
        cur_name    = tr_name[idx];
        cur_res     = tr_res[idx];
        cur_stat    = tr_stat[idx];
        in_valid_i  = 1'b1;
        do @(posedge clk_i); while (!in_ready_o);
        n_issued++;
        @(negedge clk_i);
      end
    end
    in_valid_i = 1'b0;

    while (exp_name.size() != 0) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    // Both lanes must be empty once the last item has left
    assert (!busy_o && !out_valid_o && in_ready_o) else begin
      $display("Pipeline still holds items after the last output");
      fail_cnt++;
    end
    $display("Summary: %0d issued, %0d checked, %0d dropped, %0d failed",
             n_issued, n_checked, n_dropped, fail_cnt);
    if (fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* tb_clkgen.sv */
// ------------------------------------------------------------
// Free-running testbench clock, starts low at time zero
// Default half period gives a 100 ns cycle
// ------------------------------------------------------------
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int unsigned HalfPeriodNs = 50
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(HalfPeriodNs) clk_o = ~clk_o;

endmodule

/* fp_slice.sv */
// ------------------------------------------------------------
// Two-lane sign-injection and min/max slice, top level
// Latency is NumPipeRegs cycles, zero means combinational
// Lane 1 is used only for vector FP16 items
// ------------------------------------------------------------
`timescale 1ns/1ps

module fp_slice #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic [fp_slice_pkg::WORD_W-1:0]   a_i,
  input  logic [fp_slice_pkg::WORD_W-1:0]   b_i,
  input  logic                              op_i,
  input  logic [1:0]                        mod_i,
  input  logic                              fmt_i,
  input  logic                              vectorial_i,
  input  logic [TagWidth-1:0]               tag_i,
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  input  logic                              flush_i,
  output logic [fp_slice_pkg::WORD_W-1:0]   result_o,
  output logic [fp_slice_pkg::STATUS_W-1:0] status_o,
  output logic [TagWidth-1:0]               tag_o,
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic                              busy_o
);
  import fp_slice_pkg::*;

  logic [LANE_W-1:0]   lane0_a, lane0_b, lane1_a, lane1_b;
  logic [LANE_W-1:0]   lane0_result, lane1_result;
  logic [STATUS_W-1:0] lane0_status, lane1_status;
  logic [AUX_W-1:0]    dispatch_aux, result_aux;
  logic                lane0_valid, lane1_valid, lane1_in_valid;
  logic                lane0_in_ready;
  logic                lane0_out_valid, lane1_out_valid;
  logic                lane1_out_ready, lane1_result_valid;
  logic                lane0_busy, lane1_busy;

  slice_dispatch dispatch_i (
    .a_i           (a_i),
    .b_i           (b_i),
    .op_i          (op_i),
    .mod_i         (mod_i),
    .fmt_i         (fmt_i),
    .vectorial_i   (vectorial_i),
    .in_valid_i    (in_valid_i),
    .lane0_a_o     (lane0_a),
    .lane0_b_o     (lane0_b),
    .lane1_a_o     (lane1_a),
    .lane1_b_o     (lane1_b),
    .lane0_valid_o (lane0_valid),
    .lane1_valid_o (lane1_valid),
    .aux_o         (dispatch_aux)
  );

  // Lane 1 may have room where lane 0 does not, so it only takes
  // an item in the cycle lane 0 takes it too
  assign lane1_in_valid = lane1_valid & lane0_in_ready;

  // Lane 1 pops only together with a vector item from lane 0
  assign lane1_out_ready    = out_ready_i & result_aux[AUX_VEC_BIT];
  assign lane1_result_valid = lane1_out_valid & result_aux[AUX_VEC_BIT];

  lane_pipe #(
    .NumPipeRegs (NumPipeRegs),
    .TagWidth    (TagWidth)
  ) lane0_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .a_i         (lane0_a),
    .b_i         (lane0_b),
    .op_i        (op_i),
    .mod_i       (mod_i),
    .fmt_i       (fmt_i),
    .aux_i       (dispatch_aux),
    .tag_i       (tag_i),
    .in_valid_i  (lane0_valid),
    .in_ready_o  (lane0_in_ready),
    .result_o    (lane0_result),
    .status_o    (lane0_status),
    .aux_o       (result_aux),
    .tag_o       (tag_o),
    .out_valid_o (lane0_out_valid),
    .out_ready_i (out_ready_i),
    .busy_o      (lane0_busy)
  );

  lane_pipe #(
    .NumPipeRegs (NumPipeRegs),
    .TagWidth    (TagWidth)
  ) lane1_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .a_i         (lane1_a),
    .b_i         (lane1_b),
    .op_i        (op_i),
    .mod_i       (mod_i),
    .fmt_i       (fmt_i),
    .aux_i       (dispatch_aux),
    .tag_i       (tag_i),
    .in_valid_i  (lane1_in_valid),
    .in_ready_o  (),
    .result_o    (lane1_result),
    .status_o    (lane1_status),
    .aux_o       (),
    .tag_o       (),
    .out_valid_o (lane1_out_valid),
    .out_ready_i (lane1_out_ready),
    .busy_o      (lane1_busy)
  );

  result_pack pack_i (
    .lane0_result_i (lane0_result),
    .lane1_result_i (lane1_result),
    .lane0_status_i (lane0_status),
    .lane1_status_i (lane1_status),
    .aux_i          (result_aux),
    .lane1_valid_i  (lane1_result_valid),
    .result_o       (result_o),
    .status_o       (status_o)
  );

  assign in_ready_o  = lane0_in_ready;
  assign out_valid_o = lane0_out_valid;
  assign busy_o      = lane0_busy | lane1_busy;

endmodule

/* result_pack.sv */
// ------------------------------------------------------------
// Output word assembly, purely combinational
// Scalar FP16 results get an all-ones upper half (NaN-box)
// Lane 1 status counts only when lane 1 holds a vector item
// ------------------------------------------------------------
`timescale 1ns/1ps

module result_pack (
  input  logic [fp_slice_pkg::LANE_W-1:0]   lane0_result_i,
  input  logic [fp_slice_pkg::LANE_W-1:0]   lane1_result_i,
  input  logic [fp_slice_pkg::STATUS_W-1:0] lane0_status_i,
  input  logic [fp_slice_pkg::STATUS_W-1:0] lane1_status_i,
  input  logic [fp_slice_pkg::AUX_W-1:0]    aux_i,
  input  logic                              lane1_valid_i,
  output logic [fp_slice_pkg::WORD_W-1:0]   result_o,
  output logic [fp_slice_pkg::STATUS_W-1:0] status_o
);
  import fp_slice_pkg::*;

  fp_word_u            res_w;
  logic                res_fp16;
  logic                res_vec;
  logic [STATUS_W-1:0] lane1_status;

  // Aux comes from lane 0, so it describes the item at the output
  assign res_fp16 = (aux_i[AUX_FMT_BIT] == FMT_FP16);
  assign res_vec  = aux_i[AUX_VEC_BIT];

  always_comb begin : pack_word
    if (res_fp16) begin
      res_w.fp16[0] = lane0_result_i[FP16_W-1:0];
      if (res_vec) begin
        res_w.fp16[1] = lane1_result_i[FP16_W-1:0];
      end else begin
        res_w.fp16[1] = '1;
      end
    end else begin
      res_w.fp32 = lane0_result_i;
    end
  end

  assign result_o = res_w;

  // Collapse lane flags into one status word
  assign lane1_status = lane1_valid_i ? lane1_status_i : '0;
  assign status_o     = lane0_status_i | lane1_status;

endmodule

/* lane_pipe.sv */
// ------------------------------------------------------------
// One lane: sign injection or min/max, then NumPipeRegs
// valid/ready register stages (zero stages is combinational)
// flush_i drops every item in flight on the next edge
// ------------------------------------------------------------
`timescale 1ns/1ps

module lane_pipe #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              flush_i,
  input  logic [fp_slice_pkg::LANE_W-1:0]   a_i,
  input  logic [fp_slice_pkg::LANE_W-1:0]   b_i,
  input  logic                              op_i,
  input  logic [1:0]                        mod_i,
  input  logic                              fmt_i,
  input  logic [fp_slice_pkg::AUX_W-1:0]    aux_i,
  input  logic [TagWidth-1:0]               tag_i,
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  output logic [fp_slice_pkg::LANE_W-1:0]   result_o,
  output logic [fp_slice_pkg::STATUS_W-1:0] status_o,
  output logic [fp_slice_pkg::AUX_W-1:0]    aux_o,
  output logic [TagWidth-1:0]               tag_o,
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic                              busy_o
);
  import fp_slice_pkg::*;

  logic                sign_a, sign_b, inj_sign;
  logic                a_nan, b_nan, a_lt_b, do_max;
  logic [LANE_W-2:0]   mag_a, mag_b;
  logic [LANE_W-1:0]   op_result;
  logic [STATUS_W-1:0] op_status;

  // Index i holds the item after i register stages
  logic [0:NumPipeRegs][LANE_W-1:0]   pipe_result_q;
  logic [0:NumPipeRegs][STATUS_W-1:0] pipe_status_q;
  logic [0:NumPipeRegs][AUX_W-1:0]    pipe_aux_q;
  logic [0:NumPipeRegs][TagWidth-1:0] pipe_tag_q;
  logic [0:NumPipeRegs]               pipe_valid_q;
  logic [0:NumPipeRegs]               pipe_ready;

  // ----------------------------------------------------------
  // Operation
  // ----------------------------------------------------------
  always_comb begin : split_fields
    if (fmt_i == FMT_FP16) begin
      sign_a = a_i[FP16_W-1];
      sign_b = b_i[FP16_W-1];
      mag_a  = {{(LANE_W-FP16_W){1'b0}}, a_i[FP16_W-2:0]};
      mag_b  = {{(LANE_W-FP16_W){1'b0}}, b_i[FP16_W-2:0]};
    end else begin
      sign_a = a_i[LANE_W-1];
      sign_b = b_i[LANE_W-1];
      mag_a  = a_i[LANE_W-2:0];
      mag_b  = b_i[LANE_W-2:0];
    end
  end

  always_comb begin : sign_rule
    case (mod_i)
      MOD_J:   inj_sign = sign_b;
      MOD_JN:  inj_sign = ~sign_b;
      MOD_JX:  inj_sign = sign_a ^ sign_b;
      default: inj_sign = sign_b;
    endcase
  end

  assign a_nan  = is_nan(fmt_i, a_i);
  assign b_nan  = is_nan(fmt_i, b_i);
  assign do_max = (mod_i == MOD_JN);

  // Sign-magnitude order, so -0 sorts below +0
  assign a_lt_b = (sign_a != sign_b) ? sign_a
                : (sign_a ? (mag_a > mag_b) : (mag_a < mag_b));

  always_comb begin : lane_op
    // No divide, rounding or range events in this group
    op_status = '0;
    if (op_i == OP_MINMAX) begin
      if (a_nan && b_nan) begin
        op_result = canonical(fmt_i);
      end else if (a_nan) begin
        op_result = b_i;
      end else if (b_nan) begin
        op_result = a_i;
      end else begin
        op_result = (a_lt_b ^ do_max) ? a_i : b_i;
      end
      op_status[NV_BIT] = is_snan(fmt_i, a_i) | is_snan(fmt_i, b_i);
      if (fmt_i == FMT_FP16) begin
        op_result[LANE_W-1:FP16_W] = '1;
      end
    end else if (fmt_i == FMT_FP16) begin
      op_result = {{(LANE_W-FP16_W){1'b1}}, inj_sign, a_i[FP16_W-2:0]};
    end else begin
      op_result = {inj_sign, a_i[LANE_W-2:0]};
    end
  end

  // ----------------------------------------------------------
  // Pipeline
  // ----------------------------------------------------------
  assign pipe_result_q[0] = op_result;
  assign pipe_status_q[0] = op_status;
  assign pipe_aux_q[0]    = aux_i;
  assign pipe_tag_q[0]    = tag_i;
  assign pipe_valid_q[0]  = in_valid_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_pipe_stage
    logic reg_ena;

    // Advance when the next stage moves on or only holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid_q[i+1];
    assign reg_ena       = pipe_ready[i] & pipe_valid_q[i];

    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid_q[i+1] <= pipe_valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_ena) begin
        pipe_result_q[i+1] <= pipe_result_q[i];
        pipe_status_q[i+1] <= pipe_status_q[i];
        pipe_aux_q[i+1]    <= pipe_aux_q[i];
        pipe_tag_q[i+1]    <= pipe_tag_q[i];
      end
    end
  end

  assign pipe_ready[NumPipeRegs] = out_ready_i;
  assign in_ready_o  = pipe_ready[0];
  assign out_valid_o = pipe_valid_q[NumPipeRegs];
  assign result_o    = pipe_result_q[NumPipeRegs];
  assign status_o    = pipe_status_q[NumPipeRegs];
  assign aux_o       = pipe_aux_q[NumPipeRegs];
  assign tag_o       = pipe_tag_q[NumPipeRegs];

  if (NumPipeRegs > 0) begin : gen_busy_regs
    assign busy_o = |pipe_valid_q[1:NumPipeRegs];
  end else begin : gen_busy_comb
    assign busy_o = pipe_valid_q[0];
  end

endmodule

/* slice_dispatch.sv */
// ------------------------------------------------------------
// Operand slicing for the two lanes, purely combinational
// FP16 halves are NaN-boxed into a full lane operand
// Vector mode is honoured only for FP16
// ------------------------------------------------------------
`timescale 1ns/1ps

module slice_dispatch (
  input  logic [fp_slice_pkg::WORD_W-1:0] a_i,
  input  logic [fp_slice_pkg::WORD_W-1:0] b_i,
  input  logic                            op_i,
  input  logic [1:0]                      mod_i,
  input  logic                            fmt_i,
  input  logic                            vectorial_i,
  input  logic                            in_valid_i,
  output logic [fp_slice_pkg::LANE_W-1:0] lane0_a_o,
  output logic [fp_slice_pkg::LANE_W-1:0] lane0_b_o,
  output logic [fp_slice_pkg::LANE_W-1:0] lane1_a_o,
  output logic [fp_slice_pkg::LANE_W-1:0] lane1_b_o,
  output logic                            lane0_valid_o,
  output logic                            lane1_valid_o,
  output logic [fp_slice_pkg::AUX_W-1:0]  aux_o
);
  import fp_slice_pkg::*;

  fp_word_u          a_w;
  fp_word_u          b_w;
  logic              vec_en;
  logic [LANE_W-1:0] sign_mask;

  assign a_w = a_i;
  assign b_w = b_i;

  // Upper lane only runs for packed FP16
  assign vec_en = vectorial_i & (fmt_i != FMT_FP32);

  assign lane0_valid_o = in_valid_i;
  assign lane1_valid_o = in_valid_i & vec_en;

  // Format and vector flag ride along so the output side decodes the same item
  assign aux_o[AUX_FMT_BIT] = fmt_i;
  assign aux_o[AUX_VEC_BIT] = vec_en;

  always_comb begin : slice_operands
    if (fmt_i == FMT_FP16) begin
      lane0_a_o = {{(LANE_W-FP16_W){1'b1}}, a_w.fp16[0]};
      lane0_b_o = {{(LANE_W-FP16_W){1'b1}}, b_w.fp16[0]};
      lane1_a_o = {{(LANE_W-FP16_W){1'b1}}, a_w.fp16[1]};
      lane1_b_o = {{(LANE_W-FP16_W){1'b1}}, b_w.fp16[1]};
      sign_mask = LANE_W'(1) << (FP16_W - 1);
    end else begin
      lane0_a_o = a_w.fp32;
      lane0_b_o = b_w.fp32;
      lane1_a_o = '0;
      lane1_b_o = '0;
      sign_mask = LANE_W'(1) << (LANE_W - 1);
    end

    // Sign injection only looks at the sign of b, and at the sign of a for JX,
    // so the unused bits are held at zero to keep the lane datapath quiet
    if (op_i == OP_SGNJ) begin
      lane0_b_o = lane0_b_o & sign_mask;
      lane1_b_o = lane1_b_o & sign_mask;
      if (mod_i != MOD_JX) begin
        lane0_a_o = lane0_a_o & ~sign_mask;
        lane1_a_o = lane1_a_o & ~sign_mask;
      end
    end
  end

endmodule

/* fp_slice_pkg.sv */
// ------------------------------------------------------------
// Shared constants for the two-lane FP32/FP16 slice
// Lane operands are LANE_W wide and FP16 sits in the low half
// Only the NV status flag is ever raised by this group
// ------------------------------------------------------------
package fp_slice_pkg;

  // Word layout
  localparam int unsigned WORD_W    = 32;
  localparam int unsigned NUM_LANES = 2;
  localparam int unsigned LANE_W    = 32;
  localparam int unsigned FP16_W    = 16;

  // Format, operation and modifier codes
  localparam logic       FMT_FP32   = 1'b0;
  localparam logic       FMT_FP16   = 1'b1;
  localparam logic       OP_SGNJ    = 1'b0;
  localparam logic       OP_MINMAX  = 1'b1;
  localparam logic [1:0] MOD_J      = 2'd0;
  localparam logic [1:0] MOD_JN     = 2'd1;
  localparam logic [1:0] MOD_JX     = 2'd2;

  // Status flags, IEEE order NV DZ OF UF NX from the top
  localparam int unsigned STATUS_W = 5;
  localparam int unsigned NV_BIT   = 4;
  localparam int unsigned DZ_BIT   = 3;
  localparam int unsigned OF_BIT   = 2;
  localparam int unsigned UF_BIT   = 1;
  localparam int unsigned NX_BIT   = 0;

  // Aux bits travelling with each item
  localparam int unsigned AUX_W       = 2;
  localparam int unsigned AUX_FMT_BIT = 1;
  localparam int unsigned AUX_VEC_BIT = 0;

  localparam logic [WORD_W-1:0] CNAN32 = 32'h7fc0_0000;
  localparam logic [FP16_W-1:0] CNAN16 = 16'h7e00;

  // One word seen as a single FP32 value or as two FP16 halves
  typedef union packed {
    logic [WORD_W-1:0]                 fp32;
    logic [NUM_LANES-1:0][FP16_W-1:0]  fp16;
  } fp_word_u;

  function automatic logic is_nan(input logic fmt, input logic [LANE_W-1:0] x);
    if (fmt == FMT_FP16) begin
      return (x[14:10] == '1) && (x[9:0] != '0);
    end
    return (x[30:23] == '1) && (x[22:0] != '0);
  endfunction

  // Signaling when the quiet bit (top mantissa bit) is clear
  function automatic logic is_snan(input logic fmt, input logic [LANE_W-1:0] x);
    if (fmt == FMT_FP16) begin
      return is_nan(fmt, x) && !x[9];
    end
    return is_nan(fmt, x) && !x[22];
  endfunction

  function automatic logic [LANE_W-1:0] canonical(input logic fmt);
    if (fmt == FMT_FP16) begin
      return {{(LANE_W-FP16_W){1'b1}}, CNAN16};
    end
    return CNAN32;
  endfunction

endpackage
